//--- common/id_pkg.sv
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int CLA_GROUPS = XLEN / 4;

    localparam logic [REG_ADDR_W-1:0] LINK_REG   = 5'd1;
    localparam logic [XLEN-1:0]       INST_BYTES = 32'd4;

    // 3R and shift-immediate, matched on inst[31:15]
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_SLT    = 17'h00024;
    localparam logic [16:0] OPC_SLTU   = 17'h00025;
    localparam logic [16:0] OPC_NOR    = 17'h00028;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;
    localparam logic [16:0] OPC_SLL_W  = 17'h0002e;
    localparam logic [16:0] OPC_SRL_W  = 17'h0002f;
    localparam logic [16:0] OPC_SRA_W  = 17'h00030;
    localparam logic [16:0] OPC_SLLI_W = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W = 17'h00091;

    // 2RI12 alu and memory, matched on inst[31:22]
    localparam logic [9:0] OPC_SLTI   = 10'h008;
    localparam logic [9:0] OPC_SLTUI  = 10'h009;
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_ANDI   = 10'h00d;
    localparam logic [9:0] OPC_ORI    = 10'h00e;
    localparam logic [9:0] OPC_XORI   = 10'h00f;
    localparam logic [9:0] OPC_LD_B   = 10'h0a0;
    localparam logic [9:0] OPC_LD_H   = 10'h0a1;
    localparam logic [9:0] OPC_LD_W   = 10'h0a2;
    localparam logic [9:0] OPC_ST_B   = 10'h0a4;
    localparam logic [9:0] OPC_ST_H   = 10'h0a5;
    localparam logic [9:0] OPC_ST_W   = 10'h0a6;
    localparam logic [9:0] OPC_LD_BU  = 10'h0a8;
    localparam logic [9:0] OPC_LD_HU  = 10'h0a9;

    // upper immediate on inst[31:25], branches on inst[31:26]
    localparam logic [6:0] OPC_LU12I_W   = 7'h0a;
    localparam logic [6:0] OPC_PCADDU12I = 7'h0e;
    localparam logic [5:0] OPC_JIRL      = 6'h13;
    localparam logic [5:0] OPC_B         = 6'h14;
    localparam logic [5:0] OPC_BL        = 6'h15;
    localparam logic [5:0] OPC_BEQ       = 6'h16;
    localparam logic [5:0] OPC_BNE       = 6'h17;
    localparam logic [5:0] OPC_BLT       = 6'h18;
    localparam logic [5:0] OPC_BGE       = 6'h19;
    localparam logic [5:0] OPC_BLTU      = 6'h1a;
    localparam logic [5:0] OPC_BGEU      = 6'h1b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // nine memory ops need four bits
    typedef enum logic [3:0] {
        MEM_NONE, MEM_LD_B, MEM_LD_BU, MEM_LD_H, MEM_LD_HU,
        MEM_LD_W, MEM_ST_B, MEM_ST_H, MEM_ST_W
    } mem_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU,
        BR_B, BR_BL, BR_JIRL
    } br_kind_e;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } fwd_t;

    // is_load: ex data is only an address, value not ready
    typedef struct packed {
        logic is_load;
        fwd_t fwd;
    } ex_fwd_t;

    typedef struct packed {
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        br_kind_e              br_kind;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       br_offs;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  need_rs1;
        logic                  need_rs2;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        logic [XLEN-1:0]       src1;
        logic [XLEN-1:0]       src2;
        logic [XLEN-1:0]       st_data;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       pc;
    } ex_pkt_t;

endpackage

//--- branch/cla_adder32.sv
`timescale 1ns/1ns

module cla_adder32 (
    input  logic [id_pkg::XLEN-1:0] i_a,
    input  logic [id_pkg::XLEN-1:0] i_b,
    input  logic                    i_cin,
    output logic [id_pkg::XLEN-1:0] o_sum,
    output logic                    o_sign,
    output logic                    o_zero,
    output logic                    o_carry,
    output logic                    o_ovf
);

    logic [id_pkg::XLEN-1:0]       g;
    logic [id_pkg::XLEN-1:0]       p;
    logic [id_pkg::XLEN-1:0]       c;
    logic [id_pkg::CLA_GROUPS-1:0] gg;
    logic [id_pkg::CLA_GROUPS-1:0] gp;
    logic [id_pkg::CLA_GROUPS:0]   gc;

    assign g = i_a & i_b;
    assign p = i_a ^ i_b;

    // first level, 4-bit groups
    for (genvar k = 0; k < id_pkg::CLA_GROUPS; k++) begin : g_group
        logic [3:0] gk;
        logic [3:0] pk;
        assign gk       = g[4*k +: 4];
        assign pk       = p[4*k +: 4];
        assign gg[k]    = gk[3] | (pk[3] & gk[2]) | ((&pk[3:2]) & gk[1]) | ((&pk[3:1]) & gk[0]);
        assign gp[k]    = &pk;
        assign c[4*k]   = gc[k];
        assign c[4*k+1] = gk[0] | (pk[0] & gc[k]);
        assign c[4*k+2] = gk[1] | (pk[1] & gk[0]) | ((&pk[1:0]) & gc[k]);
        assign c[4*k+3] = gk[2] | (pk[2] & gk[1]) | ((&pk[2:1]) & gk[0]) |
                          ((&pk[2:0]) & gc[k]);
    end

    // second level, each group carry as a flat sum of products
    always_comb begin
        logic term;
        term  = 1'b0;
        gc[0] = i_cin;
        for (int k = 1; k <= id_pkg::CLA_GROUPS; k++) begin
            gc[k] = i_cin;
            for (int j = 0; j < k; j++) begin
                gc[k] = gc[k] & gp[j];
            end
            for (int j = 0; j < k; j++) begin
                term = gg[j];
                for (int m = j + 1; m < k; m++) begin
                    term = term & gp[m];
                end
                gc[k] = gc[k] | term;
            end
        end
    end

    assign o_sum   = p ^ c;
    assign o_sign  = o_sum[id_pkg::XLEN-1];
    assign o_zero  = ~|o_sum;
    assign o_carry = gc[id_pkg::CLA_GROUPS];
    assign o_ovf   = c[id_pkg::XLEN-1] ^ gc[id_pkg::CLA_GROUPS];

endmodule

//--- branch/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  id_pkg::br_kind_e        i_br_kind,
    input  logic [id_pkg::XLEN-1:0] i_pc,
    input  logic [id_pkg::XLEN-1:0] i_rs1_val,
    input  logic [id_pkg::XLEN-1:0] i_rs2_val,
    input  logic [id_pkg::XLEN-1:0] i_offs,
    output logic                    o_taken,
    output logic [id_pkg::XLEN-1:0] o_target
);

    logic                    sign;
    logic                    zero;
    logic                    carry;
    logic                    ovf;
    logic                    lt_s;
    logic                    lt_u;
    logic [id_pkg::XLEN-1:0] base;

    // rs1 - rs2, only the flags matter
    cla_adder32 u_cmp (
        .i_a     (i_rs1_val),
        .i_b     (~i_rs2_val),
        .i_cin   (1'b1),
        .o_sum   (),
        .o_sign  (sign),
        .o_zero  (zero),
        .o_carry (carry),
        .o_ovf   (ovf)
    );

    assign lt_s = ovf ^ sign;
    assign lt_u = ~carry;
    assign base = (i_br_kind == id_pkg::BR_JIRL) ? i_rs1_val : i_pc;

    cla_adder32 u_target (
        .i_a     (base),
        .i_b     (i_offs),
        .i_cin   (1'b0),
        .o_sum   (o_target),
        .o_sign  (),
        .o_zero  (),
        .o_carry (),
        .o_ovf   ()
    );

    always_comb begin
        case (i_br_kind)
            id_pkg::BR_BEQ:  o_taken = zero;
            id_pkg::BR_BNE:  o_taken = ~zero;
            id_pkg::BR_BLT:  o_taken = lt_s;
            id_pkg::BR_BGE:  o_taken = ~lt_s;
            id_pkg::BR_BLTU: o_taken = lt_u;
            id_pkg::BR_BGEU: o_taken = ~lt_u;
            id_pkg::BR_B, id_pkg::BR_BL, id_pkg::BR_JIRL: o_taken = 1'b1;
            default:         o_taken = 1'b0;
        endcase
    end

endmodule

//--- decode/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  logic [id_pkg::XLEN-1:0] i_inst,
    output id_pkg::dec_ctrl_t       o_ctrl
);

    logic [id_pkg::REG_ADDR_W-1:0] rd;
    logic [id_pkg::REG_ADDR_W-1:0] rj;
    logic [id_pkg::REG_ADDR_W-1:0] rk;
    logic [id_pkg::XLEN-1:0]       simm12;
    logic [id_pkg::XLEN-1:0]       uimm12;
    logic [id_pkg::XLEN-1:0]       offs16;
    logic [id_pkg::XLEN-1:0]       offs26;

    logic                          r3_hit;
    logic                          r3_imm;
    id_pkg::alu_op_e               r3_op;
    logic                          i12_hit;
    id_pkg::alu_op_e               i12_op;
    id_pkg::mem_op_e               mem_op;
    id_pkg::br_kind_e              br_kind;
    logic                          is_lu12i;
    logic                          is_pcadd;
    logic                          is_store;
    logic                          is_cond_br;

    assign rd     = i_inst[4:0];
    assign rj     = i_inst[9:5];
    assign rk     = i_inst[14:10];
    assign simm12 = {{20{i_inst[21]}}, i_inst[21:10]};
    assign uimm12 = {20'b0, i_inst[21:10]};
    assign offs16 = {{14{i_inst[25]}}, i_inst[25:10], 2'b00};
    // offs26 high part sits in the low bits of the word
    assign offs26 = {{4{i_inst[9]}}, i_inst[9:0], i_inst[25:10], 2'b00};

    assign is_lu12i   = i_inst[31:25] == id_pkg::OPC_LU12I_W;
    assign is_pcadd   = i_inst[31:25] == id_pkg::OPC_PCADDU12I;
    assign is_store   = mem_op inside {id_pkg::MEM_ST_B, id_pkg::MEM_ST_H, id_pkg::MEM_ST_W};
    assign is_cond_br = br_kind inside {id_pkg::BR_BEQ, id_pkg::BR_BNE, id_pkg::BR_BLT,
                                        id_pkg::BR_BGE, id_pkg::BR_BLTU, id_pkg::BR_BGEU};

    always_comb begin
        r3_hit = 1'b1;
        r3_imm = 1'b0;
        r3_op  = id_pkg::ALU_ADD;
        case (i_inst[31:15])
            id_pkg::OPC_ADD_W: r3_op = id_pkg::ALU_ADD;
            id_pkg::OPC_SUB_W: r3_op = id_pkg::ALU_SUB;
            id_pkg::OPC_SLT:   r3_op = id_pkg::ALU_SLT;
            id_pkg::OPC_SLTU:  r3_op = id_pkg::ALU_SLTU;
            id_pkg::OPC_NOR:   r3_op = id_pkg::ALU_NOR;
            id_pkg::OPC_AND:   r3_op = id_pkg::ALU_AND;
            id_pkg::OPC_OR:    r3_op = id_pkg::ALU_OR;
            id_pkg::OPC_XOR:   r3_op = id_pkg::ALU_XOR;
            id_pkg::OPC_SLL_W: r3_op = id_pkg::ALU_SLL;
            id_pkg::OPC_SRL_W: r3_op = id_pkg::ALU_SRL;
            id_pkg::OPC_SRA_W: r3_op = id_pkg::ALU_SRA;
            id_pkg::OPC_SLLI_W: begin
                r3_op  = id_pkg::ALU_SLL;
                r3_imm = 1'b1;
            end
            id_pkg::OPC_SRLI_W: begin
                r3_op  = id_pkg::ALU_SRL;
                r3_imm = 1'b1;
            end
            id_pkg::OPC_SRAI_W: begin
                r3_op  = id_pkg::ALU_SRA;
                r3_imm = 1'b1;
            end
            default: r3_hit = 1'b0;
        endcase
    end

    // loads and stores keep ALU_ADD for the address
    always_comb begin
        i12_hit = 1'b1;
        i12_op  = id_pkg::ALU_ADD;
        mem_op  = id_pkg::MEM_NONE;
        case (i_inst[31:22])
            id_pkg::OPC_SLTI:   i12_op = id_pkg::ALU_SLT;
            id_pkg::OPC_SLTUI:  i12_op = id_pkg::ALU_SLTU;
            id_pkg::OPC_ADDI_W: i12_op = id_pkg::ALU_ADD;
            id_pkg::OPC_ANDI:   i12_op = id_pkg::ALU_AND;
            id_pkg::OPC_ORI:    i12_op = id_pkg::ALU_OR;
            id_pkg::OPC_XORI:   i12_op = id_pkg::ALU_XOR;
            id_pkg::OPC_LD_B:   mem_op = id_pkg::MEM_LD_B;
            id_pkg::OPC_LD_H:   mem_op = id_pkg::MEM_LD_H;
            id_pkg::OPC_LD_W:   mem_op = id_pkg::MEM_LD_W;
            id_pkg::OPC_LD_BU:  mem_op = id_pkg::MEM_LD_BU;
            id_pkg::OPC_LD_HU:  mem_op = id_pkg::MEM_LD_HU;
            id_pkg::OPC_ST_B:   mem_op = id_pkg::MEM_ST_B;
            id_pkg::OPC_ST_H:   mem_op = id_pkg::MEM_ST_H;
            id_pkg::OPC_ST_W:   mem_op = id_pkg::MEM_ST_W;
            default:            i12_hit = 1'b0;
        endcase
    end

    always_comb begin
        case (i_inst[31:26])
            id_pkg::OPC_JIRL: br_kind = id_pkg::BR_JIRL;
            id_pkg::OPC_B:    br_kind = id_pkg::BR_B;
            id_pkg::OPC_BL:   br_kind = id_pkg::BR_BL;
            id_pkg::OPC_BEQ:  br_kind = id_pkg::BR_BEQ;
            id_pkg::OPC_BNE:  br_kind = id_pkg::BR_BNE;
            id_pkg::OPC_BLT:  br_kind = id_pkg::BR_BLT;
            id_pkg::OPC_BGE:  br_kind = id_pkg::BR_BGE;
            id_pkg::OPC_BLTU: br_kind = id_pkg::BR_BLTU;
            id_pkg::OPC_BGEU: br_kind = id_pkg::BR_BGEU;
            default:          br_kind = id_pkg::BR_NONE;
        endcase
    end

    always_comb begin
        o_ctrl         = '0;
        o_ctrl.mem_op  = mem_op;
        o_ctrl.br_kind = br_kind;
        o_ctrl.rs1     = rj;
        o_ctrl.rs2     = (is_store || is_cond_br) ? rd : rk;
        o_ctrl.dest    = (br_kind == id_pkg::BR_BL) ? id_pkg::LINK_REG : rd;
        o_ctrl.br_offs = (br_kind inside {id_pkg::BR_B, id_pkg::BR_BL}) ? offs26 : offs16;
        if (r3_hit) begin
            o_ctrl.alu_op      = r3_op;
            o_ctrl.src2_is_imm = r3_imm;
            o_ctrl.imm         = simm12;
            o_ctrl.rf_we       = 1'b1;
            o_ctrl.need_rs1    = 1'b1;
            o_ctrl.need_rs2    = ~r3_imm;
        end else if (i12_hit) begin
            o_ctrl.alu_op      = i12_op;
            o_ctrl.src2_is_imm = 1'b1;
            o_ctrl.imm         = (i12_op inside {id_pkg::ALU_AND, id_pkg::ALU_OR,
                                                 id_pkg::ALU_XOR}) ? uimm12 : simm12;
            o_ctrl.rf_we       = ~is_store;
            o_ctrl.need_rs1    = 1'b1;
            o_ctrl.need_rs2    = is_store;
        end else if (is_lu12i || is_pcadd) begin
            o_ctrl.alu_op      = is_lu12i ? id_pkg::ALU_LUI : id_pkg::ALU_ADD;
            o_ctrl.src1_is_pc  = is_pcadd;
            o_ctrl.src2_is_imm = 1'b1;
            o_ctrl.imm         = {i_inst[24:5], 12'b0};
            o_ctrl.rf_we       = 1'b1;
        end else if (br_kind != id_pkg::BR_NONE) begin
            // link value is pc + 4
            o_ctrl.alu_op      = id_pkg::ALU_ADD;
            o_ctrl.src1_is_pc  = 1'b1;
            o_ctrl.src2_is_imm = 1'b1;
            o_ctrl.imm         = id_pkg::INST_BYTES;
            o_ctrl.rf_we       = br_kind inside {id_pkg::BR_BL, id_pkg::BR_JIRL};
            o_ctrl.need_rs1    = is_cond_br || (br_kind == id_pkg::BR_JIRL);
            o_ctrl.need_rs2    = is_cond_br;
        end
    end

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                          clk,
    input  logic [id_pkg::REG_ADDR_W-1:0] i_raddr1,
    input  logic [id_pkg::REG_ADDR_W-1:0] i_raddr2,
    input  logic                          i_we,
    input  logic [id_pkg::REG_ADDR_W-1:0] i_waddr,
    input  logic [id_pkg::XLEN-1:0]       i_wdata,
    output logic [id_pkg::XLEN-1:0]       o_rdata1,
    output logic [id_pkg::XLEN-1:0]       o_rdata2
);

    logic [id_pkg::XLEN-1:0] regs [id_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // r0 is hardwired
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

    property p_write_visible;
        logic [id_pkg::REG_ADDR_W-1:0] wa;
        logic [id_pkg::XLEN-1:0]       wd;
        @(posedge clk) (i_we, wa = i_waddr, wd = i_wdata) |=>
            (i_raddr1 != wa) || (o_rdata1 == ((wa == '0) ? '0 : wd));
    endproperty

    a_write_visible: assert property (p_write_visible);

endmodule

//--- hw/operand_bypass.sv
`timescale 1ns/1ns

module operand_bypass (
    input  logic                          clk,
    input  logic [id_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [id_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic                          i_need_rs1,
    input  logic                          i_need_rs2,
    input  id_pkg::ex_fwd_t               i_ex_fwd,
    input  id_pkg::fwd_t                  i_mem_fwd,
    input  id_pkg::fwd_t                  i_wb_fwd,
    output logic [id_pkg::XLEN-1:0]       o_rs1_val,
    output logic [id_pkg::XLEN-1:0]       o_rs2_val,
    output logic                          o_load_hazard
);

    logic [id_pkg::XLEN-1:0] rf_rdata1;
    logic [id_pkg::XLEN-1:0] rf_rdata2;

    function automatic logic fwd_hit(id_pkg::fwd_t f, logic [id_pkg::REG_ADDR_W-1:0] ra);
        return f.we && (f.waddr == ra) && (ra != '0);
    endfunction

    // youngest producer wins
    function automatic logic [id_pkg::XLEN-1:0] pick(
        logic [id_pkg::REG_ADDR_W-1:0] ra,
        logic [id_pkg::XLEN-1:0]       rf_val,
        id_pkg::fwd_t                  ex,
        id_pkg::fwd_t                  mem,
        id_pkg::fwd_t                  wb
    );
        if (fwd_hit(ex, ra)) return ex.wdata;
        if (fwd_hit(mem, ra)) return mem.wdata;
        if (fwd_hit(wb, ra)) return wb.wdata;
        return rf_val;
    endfunction

    regfile u_regfile (
        .clk      (clk),
        .i_raddr1 (i_rs1),
        .i_raddr2 (i_rs2),
        .i_we     (i_wb_fwd.we),
        .i_waddr  (i_wb_fwd.waddr),
        .i_wdata  (i_wb_fwd.wdata),
        .o_rdata1 (rf_rdata1),
        .o_rdata2 (rf_rdata2)
    );

    assign o_rs1_val = pick(i_rs1, rf_rdata1, i_ex_fwd.fwd, i_mem_fwd, i_wb_fwd);
    assign o_rs2_val = pick(i_rs2, rf_rdata2, i_ex_fwd.fwd, i_mem_fwd, i_wb_fwd);

    assign o_load_hazard = i_ex_fwd.is_load &&
                           ((i_need_rs1 && fwd_hit(i_ex_fwd.fwd, i_rs1)) ||
                            (i_need_rs2 && fwd_hit(i_ex_fwd.fwd, i_rs2)));

endmodule

//--- hw/id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    i_if_valid,
    input  id_pkg::fetch_pkt_t      i_if_pkt,
    output logic                    o_id_allowin,
    input  logic                    i_ex_allowin,
    output logic                    o_ex_valid,
    output id_pkg::ex_pkt_t         o_ex_pkt,
    input  id_pkg::ex_fwd_t         i_ex_fwd,
    input  id_pkg::fwd_t            i_mem_fwd,
    input  id_pkg::fwd_t            i_wb_fwd,
    output logic                    o_br_taken,
    output logic [id_pkg::XLEN-1:0] o_br_target
);

    id_pkg::fetch_pkt_t      if_pkt_q;
    logic                    id_valid;
    id_pkg::dec_ctrl_t       ctrl;
    logic [id_pkg::XLEN-1:0] rs1_val;
    logic [id_pkg::XLEN-1:0] rs2_val;
    logic                    load_hazard;
    logic                    ready_go;
    logic                    br_hit;

    assign ready_go     = ~load_hazard;
    assign o_id_allowin = ~id_valid | (ready_go & i_ex_allowin);
    assign o_ex_valid   = id_valid & ready_go;
    assign o_br_taken   = id_valid & ready_go & br_hit;

    // a taken branch drops whatever fetch offers once it moves on
    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (o_br_taken && i_ex_allowin) begin
            id_valid <= 1'b0;
        end else if (o_id_allowin) begin
            id_valid <= i_if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_if_valid && o_id_allowin) begin
            if_pkt_q <= i_if_pkt;
        end
    end

    inst_decoder u_decoder (
        .i_inst (if_pkt_q.inst),
        .o_ctrl (ctrl)
    );

    operand_bypass u_bypass (
        .clk           (clk),
        .i_rs1         (ctrl.rs1),
        .i_rs2         (ctrl.rs2),
        .i_need_rs1    (ctrl.need_rs1),
        .i_need_rs2    (ctrl.need_rs2),
        .i_ex_fwd      (i_ex_fwd),
        .i_mem_fwd     (i_mem_fwd),
        .i_wb_fwd      (i_wb_fwd),
        .o_rs1_val     (rs1_val),
        .o_rs2_val     (rs2_val),
        .o_load_hazard (load_hazard)
    );

    branch_unit u_branch (
        .i_br_kind (ctrl.br_kind),
        .i_pc      (if_pkt_q.pc),
        .i_rs1_val (rs1_val),
        .i_rs2_val (rs2_val),
        .i_offs    (ctrl.br_offs),
        .o_taken   (br_hit),
        .o_target  (o_br_target)
    );

    assign o_ex_pkt = '{
        alu_op:  ctrl.alu_op,
        mem_op:  ctrl.mem_op,
        src1:    ctrl.src1_is_pc ? if_pkt_q.pc : rs1_val,
        src2:    ctrl.src2_is_imm ? ctrl.imm : rs2_val,
        st_data: rs2_val,
        rf_we:   ctrl.rf_we,
        dest:    ctrl.dest,
        pc:      if_pkt_q.pc
    };

    // load-use keeps the same instruction parked until ex resolves
    a_hazard_holds: assert property (@(posedge clk) disable iff (!resetn)
        id_valid && load_hazard |=> id_valid && $stable(if_pkt_q));

    a_backpressure_stable: assert property (@(posedge clk) disable iff (!resetn)
        o_ex_valid && !i_ex_allowin |=> o_ex_valid && $stable(o_ex_pkt));

endmodule

//--- tb/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;

    localparam int MAX_STEPS       = 64;
    localparam int NUM_COLS        = 21;
    localparam int CYCLES_PER_STEP = 20;

    // golden file columns
    localparam int C_MODE = 0;
    localparam int C_INST = 1;
    localparam int C_PC   = 2;
    localparam int C_EXWE = 3;
    localparam int C_EXLD = 4;
    localparam int C_EXA  = 5;
    localparam int C_EXD  = 6;
    localparam int C_MWE  = 7;
    localparam int C_MA   = 8;
    localparam int C_MD   = 9;
    localparam int C_WWE  = 10;
    localparam int C_WA   = 11;
    localparam int C_WD   = 12;
    localparam int C_ALW  = 13;
    localparam int C_V    = 14;
    localparam int C_ALU  = 15;
    localparam int C_S1   = 16;
    localparam int C_S2   = 17;
    localparam int C_DST  = 18;
    localparam int C_TK   = 19;
    localparam int C_TGT  = 20;

    logic                    clk;
    logic                    resetn;
    logic                    i_if_valid;
    id_pkg::fetch_pkt_t      i_if_pkt;
    logic                    o_id_allowin;
    logic                    i_ex_allowin;
    logic                    o_ex_valid;
    id_pkg::ex_pkt_t         o_ex_pkt;
    id_pkg::ex_fwd_t         i_ex_fwd;
    id_pkg::fwd_t            i_mem_fwd;
    id_pkg::fwd_t            i_wb_fwd;
    logic                    o_br_taken;
    logic [id_pkg::XLEN-1:0] o_br_target;

    logic [31:0] gold [MAX_STEPS][NUM_COLS];
    int          n_steps;
    int          cur_step;
    int          test_errors;
    int          failed_steps;
    logic        loaded;
    logic        load_ok;
    logic [31:0] lfsr;

    id_stage i_dut (
        .clk          (clk),
        .resetn       (resetn),
        .i_if_valid   (i_if_valid),
        .i_if_pkt     (i_if_pkt),
        .o_id_allowin (o_id_allowin),
        .i_ex_allowin (i_ex_allowin),
        .o_ex_valid   (o_ex_valid),
        .o_ex_pkt     (o_ex_pkt),
        .i_ex_fwd     (i_ex_fwd),
        .i_mem_fwd    (i_mem_fwd),
        .i_wb_fwd     (i_wb_fwd),
        .o_br_taken   (o_br_taken),
        .o_br_target  (o_br_target)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    code;
        string line;
        fd = $fopen("tb/id_golden.txt", "r");
        load_ok = (fd != 0);
        n_steps = 0;
        if (fd != 0) begin
            while (!$feof(fd) && n_steps < MAX_STEPS) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        gold[n_steps][0], gold[n_steps][1], gold[n_steps][2],
                        gold[n_steps][3], gold[n_steps][4], gold[n_steps][5],
                        gold[n_steps][6], gold[n_steps][7], gold[n_steps][8],
                        gold[n_steps][9], gold[n_steps][10], gold[n_steps][11],
                        gold[n_steps][12], gold[n_steps][13], gold[n_steps][14],
                        gold[n_steps][15], gold[n_steps][16], gold[n_steps][17],
                        gold[n_steps][18], gold[n_steps][19], gold[n_steps][20]);
                    if (code == NUM_COLS) begin
                        n_steps++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_forwarding(input int s);
        i_ex_fwd.is_load   = gold[s][C_EXLD][0];
        i_ex_fwd.fwd.we    = gold[s][C_EXWE][0];
        i_ex_fwd.fwd.waddr = gold[s][C_EXA][4:0];
        i_ex_fwd.fwd.wdata = gold[s][C_EXD];
        i_mem_fwd.we       = gold[s][C_MWE][0];
        i_mem_fwd.waddr    = gold[s][C_MA][4:0];
        i_mem_fwd.wdata    = gold[s][C_MD];
        i_wb_fwd.we        = gold[s][C_WWE][0];
        i_wb_fwd.waddr     = gold[s][C_WA][4:0];
        i_wb_fwd.wdata     = gold[s][C_WD];
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: step %0d %s is %h, expected %h",
                     $time, cur_step, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_outputs(input int s);
        check_value("o_ex_valid", 32'(o_ex_valid), gold[s][C_V]);
        if (gold[s][C_V][0]) begin
            check_value("alu_op", 32'(o_ex_pkt.alu_op), gold[s][C_ALU]);
            check_value("src1", o_ex_pkt.src1, gold[s][C_S1]);
            check_value("src2", o_ex_pkt.src2, gold[s][C_S2]);
            check_value("dest", 32'(o_ex_pkt.dest), gold[s][C_DST]);
            check_value("pc", o_ex_pkt.pc, gold[s][C_PC]);
        end else begin
            // load-use stall must also refuse new fetches
            check_value("o_id_allowin", 32'(o_id_allowin), 32'd0);
        end
        check_value("o_br_taken", 32'(o_br_taken), gold[s][C_TK]);
        if (gold[s][C_TK][0]) begin
            check_value("o_br_target", o_br_target, gold[s][C_TGT]);
        end
    endtask

    task automatic run_new_inst(input int s);
        int              stall;
        logic            held_valid;
        id_pkg::ex_pkt_t held_pkt;
        @(negedge clk);
        if (o_ex_valid && !i_ex_allowin) begin
            // a held packet leaves before the next step's forwarding
            i_ex_allowin = 1'b1;
            @(negedge clk);
        end
        i_if_pkt.inst = gold[s][C_INST];
        i_if_pkt.pc   = gold[s][C_PC];
        i_if_valid    = 1'b1;
        i_ex_allowin  = gold[s][C_ALW][0];
        drive_forwarding(s);
        #1;
        while (!o_id_allowin) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        i_if_valid = 1'b0;
        stall = 0;
        if (gold[s][C_V][0] && !gold[s][C_TK][0]) begin
            random_bits(2, stall);
        end
        if (stall > 0) begin
            i_ex_allowin = 1'b0;
        end
        #2;
        check_outputs(s);
        held_valid = o_ex_valid;
        held_pkt   = o_ex_pkt;
        for (int k = 0; k < stall; k++) begin
            @(negedge clk);
            if (k == stall - 1) begin
                i_ex_allowin = gold[s][C_ALW][0];
            end
            #2;
            if (o_ex_valid !== held_valid || o_ex_pkt !== held_pkt) begin
                $display("mismatch at %0t ns: step %0d packet changed under back-pressure",
                         $time, s);
                test_errors++;
            end
        end
        if (gold[s][C_TK][0]) begin
            // wrong-path fetch right behind the branch
            i_if_pkt.inst = 32'h001020c9;
            i_if_pkt.pc   = 32'h000dead0;
            i_if_valid    = 1'b1;
            @(posedge clk);
            @(negedge clk);
            i_if_valid = 1'b0;
            #2;
            check_value("o_ex_valid after taken branch", 32'(o_ex_valid), 32'd0);
        end
    endtask

    task automatic run_hold(input int s);
        @(negedge clk);
        i_if_valid   = 1'b0;
        i_ex_allowin = gold[s][C_ALW][0];
        drive_forwarding(s);
        #2;
        check_outputs(s);
    endtask

    initial begin
        wait (loaded === 1'b1);
        repeat (n_steps * CYCLES_PER_STEP + 10) @(posedge clk);
        $display("timeout: the stage stopped accepting instructions");
        $display("Test failed");
        $finish;
    end

    initial begin
        loaded       = 1'b0;
        clk          = 1'b0;
        resetn       = 1'b0;
        i_if_valid   = 1'b0;
        i_if_pkt     = '0;
        i_ex_allowin = 1'b1;
        i_ex_fwd     = '0;
        i_mem_fwd    = '0;
        i_wb_fwd     = '0;
        lfsr         = 32'h136f;
        test_errors  = 0;
        failed_steps = 0;
        load_golden();
        if (!load_ok || n_steps == 0) begin
            $display("could not read any step from tb/id_golden.txt");
            $display("Test failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (3) @(posedge clk);
            @(negedge clk);
            resetn = 1'b1;
            #2;
            if (o_ex_valid !== 1'b0 || o_br_taken !== 1'b0 || o_id_allowin !== 1'b1) begin
                $display("mismatch at %0t ns: outputs after reset are wrong", $time);
                failed_steps++;
            end
            for (int s = 0; s < n_steps; s++) begin
                cur_step    = s;
                test_errors = 0;
                if (gold[s][C_MODE] == 0) begin
                    run_new_inst(s);
                end else begin
                    run_hold(s);
                end
                if (test_errors == 0) begin
                    $display("step %0d: pass", s);
                end else begin
                    $display("step %0d: FAIL with %0d errors", s, test_errors);
                    failed_steps++;
                end
            end
            $display("%0d steps run, %0d passed, %0d failed",
                     n_steps, n_steps - failed_steps, failed_steps);
            if (failed_steps == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

//--- tb/id_golden.txt
# mode inst pc | ex: we ld addr data | mem: we addr data | wb: we addr data | ex_allowin
# expect: valid alu_op src1 src2 dest taken target  (mode 0 new instruction, 1 hold)
0 02bffc05 00001000 0 0 00 00000000 0 00 00000000 1 06 00000006 1 1 0 00000000 ffffffff 05 0 0
0 03a000c7 00001004 0 0 00 00000000 0 00 00000000 1 08 80000000 1 1 6 00000006 00000800 07 0 0
0 001020c9 00001008 1 0 06 aaaaaaaa 1 06 bbbbbbbb 1 06 cccccccc 1 1 0 aaaaaaaa 80000000 09 0 0
0 001020c9 0000100c 0 0 06 eeeeeeee 1 06 bbbbbbbb 1 06 dddddddd 1 1 0 bbbbbbbb 80000000 09 0 0
0 001020c9 00001010 0 0 00 00000000 0 00 00000000 1 06 00000060 1 1 0 00000060 80000000 09 0 0
0 00102009 00001014 1 0 00 ffffffff 1 00 ffffffff 1 00 ffffffff 1 1 0 00000000 80000000 09 0 0
0 00408c0a 00001018 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 8 00000000 00000023 0a 0 0
0 001018ec 0000101c 1 1 07 00000000 0 00 00000000 0 00 00000000 1 0 0 00000000 00000000 0c 0 0
1 001018ec 0000101c 0 0 00 00000000 1 07 00000777 0 00 00000000 0 1 0 00000777 00000060 0c 0 0
1 001018ec 0000101c 0 0 00 00000000 1 07 00000777 0 00 00000000 0 1 0 00000777 00000060 0c 0 0
0 60001106 00002000 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 00002000 00000004 06 1 00002010
0 68001106 00002100 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 00002100 00000004 06 0 0
0 67fff0c8 00003000 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 00003000 00000004 08 1 00002ff0
0 58000400 00003100 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 00003100 00000004 00 1 00003104
0 580004c8 00003200 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 00003200 00000004 08 0 0
0 54010000 00004000 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 00004000 00000004 01 1 00004100
0 53f003ff 00005000 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 00005000 00000004 1f 1 00004000
0 4c0008c1 00006000 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 00006000 00000004 01 1 00000068
0 1c2468ad 00007000 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 00007000 12345000 0d 0 0
0 1557800e 00007004 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 b 00000000 abc00000 0e 0 0
0 299ff106 00007008 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 80000000 000007fc 06 0 0
0 023ff8cf 0000700c 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 2 00000060 fffffffe 0f 0 0

//--- build.f
common/id_pkg.sv
branch/cla_adder32.sv
branch/branch_unit.sv
decode/inst_decoder.sv
hw/regfile.sv
hw/operand_bypass.sv
hw/id_stage.sv
tb/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - common/id_pkg.sv
  - branch/cla_adder32.sv
  - branch/branch_unit.sv
  - decode/inst_decoder.sv
  - hw/regfile.sv
  - hw/operand_bypass.sv
  - hw/id_stage.sv
  - target: test
    files:
      - tb/tb_id_stage.sv
